/* tb.f */
+incdir+verif
rtl/paint_pkg.sv
rtl/palette_regs.sv
rtl/scan_sequencer.sv
rtl/rect_filler.sv
rtl/board_display.sv
verif/board_display_tb.sv

/* run.sh */
#!/bin/sh
# build the board display testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module board_display_tb -o sim_board_display &&
./obj_dir/sim_board_display && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verif/display_model.svh */
`ifndef DISPLAY_MODEL_SVH
`define DISPLAY_MODEL_SVH

// reference for the write stream of one frame
// relies on BOARD_W, BOARD_H, CELL_PX and CELLS of the including module

// writes the DUT should make in the coming frame, in order
pix_wr_t model_q[$];

// one filled rectangle with inclusive corners and x fastest
function automatic void push_rect(input int x0, input int y0, input int x1, input int y1,
	input color_t color);
	pix_wr_t wr;
	for (int y = y0; y <= y1; y++)
	begin
		for (int x = x0; x <= x1; x++)
		begin
			wr.x     = COORD_BITS'(x);
			wr.y     = COORD_BITS'(y);
			wr.color = color;
			model_q.push_back(wr);
		end
	end
endfunction

// stones in cell raster order, then the cursor painted on top
function automatic void compute_frame(input cell_t [CELLS-1:0] brd, input int cx,
	input int cy, input pal_t colors);
	int st;
	int px;
	int py;
	model_q.delete();
	for (int row = 0; row < BOARD_H; row++)
	begin
		for (int col = 0; col < BOARD_W; col++)
		begin
			st = int'(brd[row * BOARD_W + col]);
			px = col * CELL_PX;
			py = row * CELL_PX;
			// square one pixel inside the cell border in the color of state minus one
			if (st != 0)
				push_rect(px + 1, py + 1, px + CELL_PX - 2, py + CELL_PX - 2, colors[st - 1]);
		end
	end
	// whole cell in the cursor entry
	px = cx * CELL_PX;
	py = cy * CELL_PX;
	push_rect(px, py, px + CELL_PX - 1, py + CELL_PX - 1, colors[PAL_CURSOR]);
endfunction

`endif

/* verif/board_display_tb.sv */
`timescale 1ns/1ns

module board_display_tb import paint_pkg::*;
();

	localparam int BOARD_W      = 8;
	localparam int BOARD_H      = 8;
	localparam int CELL_PX      = 8;
	localparam int CELLS        = BOARD_W * BOARD_H;
	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_FRAMES   = 12;
	// worst case has every cell occupied plus the cursor square and frame_done
	localparam int WORST_FRAME  = CELLS * ((CELL_PX - 2) * (CELL_PX - 2) + 2) +
		CELL_PX * CELL_PX + 4;
	localparam int TIMEOUT_NS   =
		(RESET_CYCLES + NUM_FRAMES * WORST_FRAME * 3 / 2) * CLK_PERIOD;

	logic                  Clck;
	logic                  rst_n;
	cell_t [CELLS-1:0]     board;
	logic [COORD_BITS-1:0] cursor_x;
	logic [COORD_BITS-1:0] cursor_y;
	logic                  cfg_we;
	pal_idx_t              cfg_idx;
	color_t                cfg_color;
	pix_wr_t               pix;
	logic                  pix_we;
	logic                  frame_done;

	// writes seen in the current frame and the palette the host has set
	pix_wr_t got_q[$];
	pal_t    pal_shadow;

	`include "display_model.svh"

	board_display #(
		.BOARD_W (BOARD_W),
		.BOARD_H (BOARD_H),
		.CELL_PX (CELL_PX)
	) i_board_display (
		.Clck       (Clck),
		.rst_n      (rst_n),
		.board      (board),
		.cursor_x   (cursor_x),
		.cursor_y   (cursor_y),
		.cfg_we     (cfg_we),
		.cfg_idx    (cfg_idx),
		.cfg_color  (cfg_color),
		.pix        (pix),
		.pix_we     (pix_we),
		.frame_done (frame_done)
	);

	initial
	begin
		Clck = 1'b0;
		forever #(CLK_PERIOD / 2) Clck = ~Clck;
	end

	always @(posedge Clck)
	begin
		if (rst_n && pix_we)
			got_q.push_back(pix);
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_frame(input int f);
		assert (got_q.size() == model_q.size())
		else
			stop_with_error($sformatf(
				"FAIL %0t ns: pix_we count in frame %0d expected %0d, got %0d",
				$time, f, model_q.size(), got_q.size()));
		// pix fields shown as (x, y, color)
		for (int i = 0; i < model_q.size(); i++)
		begin
			assert (got_q[i] == model_q[i])
			else
				stop_with_error($sformatf(
					"FAIL %0t ns: pix %0d of frame %0d expected (%0d,%0d,%0d), got (%0d,%0d,%0d)",
					$time, i, f, model_q[i].x, model_q[i].y, model_q[i].color,
					got_q[i].x, got_q[i].y, got_q[i].color));
		end
		got_q.delete();
	endtask

	// new board, cursor and maybe one palette entry for frame f
	task automatic apply_stimulus(input int f);
		cell_t [CELLS-1:0] brd;
		int                cx;
		int                cy;
		int                max_state;
		pal_idx_t          idx;
		color_t            col;
		max_state = (f < 4) ? 2 : 3;
		for (int i = 0; i < CELLS; i++)
			brd[i] = cell_t'(2'($urandom_range(max_state, 0)));
		cx = $urandom_range(BOARD_W - 1, 0);
		cy = $urandom_range(BOARD_H - 1, 0);
		// the last frames visit the four corners
		if (f >= 8)
		begin
			cx = (f % 2 == 1) ? BOARD_W - 1 : 0;
			cy = ((f / 2) % 2 == 1) ? BOARD_H - 1 : 0;
		end
		// cursor over a stone
		if ((f == 4 || f == 5) && brd[cy * BOARD_W + cx] == CELL_EMPTY)
			brd[cy * BOARD_W + cx] = CELL_WIN;
		if (f >= 6)
		begin
			idx = pal_idx_t'(2'($urandom_range(3, 0)));
			col = color_t'(3'($urandom_range(7, 0)));
			cfg_idx        <= idx;
			cfg_color      <= col;
			cfg_we         <= 1'b1;
			pal_shadow[idx] = col;
		end
		board    <= brd;
		cursor_x <= COORD_BITS'(cx);
		cursor_y <= COORD_BITS'(cy);
		compute_frame(brd, cx, cy, pal_shadow);
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		stop_with_error($sformatf("the run timed out after %0d ns waiting for frame_done",
			TIMEOUT_NS));
	end

	initial
	begin
		void'($urandom(395));
		rst_n     = 1'b0;
		cfg_we    = 1'b0;
		cfg_idx   = PAL_P1;
		cfg_color = '0;
		// first frame is an empty board with the reset palette
		for (int i = 0; i < CELLS; i++)
			board[i] = CELL_EMPTY;
		cursor_x = COORD_BITS'(2);
		cursor_y = COORD_BITS'(3);
		pal_shadow[PAL_P1]     = 3'd1;
		pal_shadow[PAL_P2]     = 3'd2;
		pal_shadow[PAL_WIN]    = 3'd6;
		pal_shadow[PAL_CURSOR] = 3'd4;
		compute_frame(board, 2, 3, pal_shadow);
		repeat (RESET_CYCLES)
		begin
			@(posedge Clck);
			assert (!pix_we)
			else
				stop_with_error($sformatf("FAIL %0t ns: pix_we in reset expected 0, got %0b",
					$time, pix_we));
			assert (!frame_done)
			else
				stop_with_error($sformatf("FAIL %0t ns: frame_done in reset expected 0, got %0b",
					$time, frame_done));
		end
		rst_n <= 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			@(posedge Clck);
			while (!frame_done)
				@(posedge Clck);
			check_frame(f);
			if (f + 1 < NUM_FRAMES)
				apply_stimulus(f + 1);
			@(posedge Clck);
			cfg_we <= 1'b0;
			assert (!frame_done)
			else
				stop_with_error($sformatf(
					"FAIL %0t ns: frame_done after frame %0d expected 0, got %0b",
					$time, f, frame_done));
		end
		$display("No errors");
		$finish;
	end

endmodule

/* rtl/board_display.sv */
`timescale 1ns/1ns

module board_display import paint_pkg::*;
#(
	parameter int BOARD_W = 8,
	parameter int BOARD_H = 8,
	parameter int CELL_PX = 8
)
(
	input  logic                        Clck,
	input  logic                        rst_n,
	input  cell_t [BOARD_W*BOARD_H-1:0] board,
	input  logic [COORD_BITS-1:0]       cursor_x,
	input  logic [COORD_BITS-1:0]       cursor_y,
	input  logic                        cfg_we,
	input  pal_idx_t                    cfg_idx,
	input  color_t                      cfg_color,
	output pix_wr_t                     pix,
	output logic                        pix_we,
	output logic                        frame_done
);

	pal_t  pal;
	rect_t job;
	logic  job_start;
	logic  job_done;

	palette_regs i_palette_regs (
		.Clck      (Clck),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_idx   (cfg_idx),
		.cfg_color (cfg_color),
		.pal       (pal)
	);

	scan_sequencer #(
		.BOARD_W (BOARD_W),
		.BOARD_H (BOARD_H),
		.CELL_PX (CELL_PX)
	) i_scan_sequencer (
		.Clck       (Clck),
		.rst_n      (rst_n),
		.board      (board),
		.cursor_x   (cursor_x),
		.cursor_y   (cursor_y),
		.pal        (pal),
		.job_done   (job_done),
		.job        (job),
		.job_start  (job_start),
		.frame_done (frame_done)
	);

	rect_filler i_rect_filler (
		.Clck      (Clck),
		.rst_n     (rst_n),
		.job       (job),
		.job_start (job_start),
		.pix       (pix),
		.pix_we    (pix_we),
		.job_done  (job_done)
	);

endmodule

/* rtl/rect_filler.sv */
`timescale 1ns/1ns

module rect_filler import paint_pkg::*;
(
	input  logic    Clck,
	input  logic    rst_n,
	input  rect_t   job,
	input  logic    job_start,
	output pix_wr_t pix,
	output logic    pix_we,
	output logic    job_done
);

	logic [COORD_BITS-1:0] x_org;
	logic [COORD_BITS-1:0] nxt_x;
	logic [COORD_BITS-1:0] nxt_y;

	// next raster position that wraps to the left edge at x1
	always_comb
	begin
		if (pix.x == job.x1)
		begin
			nxt_x = x_org;
			nxt_y = pix.y + 1'b1;
		end
		else
		begin
			nxt_x = pix.x + 1'b1;
			nxt_y = pix.y;
		end
	end

	// pix_we doubles as the busy flag
	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_we   <= 1'b0;
			job_done <= 1'b0;
		end
		else if (job_start)
		begin
			pix_we   <= 1'b1;
			// a single pixel job is done with its first write
			job_done <= (job.x0 == job.x1) && (job.y0 == job.y1);
		end
		else if (job_done)
		begin
			pix_we   <= 1'b0;
			job_done <= 1'b0;
		end
		else if (pix_we)
			job_done <= (nxt_x == job.x1) && (nxt_y == job.y1);
	end

	// start corner and color are latched while the far corner is read from job
	always_ff @(posedge Clck)
	begin
		if (job_start)
		begin
			pix   <= '{x: job.x0, y: job.y0, color: job.color};
			x_org <= job.x0;
		end
		else if (pix_we)
		begin
			pix.x <= nxt_x;
			pix.y <= nxt_y;
		end
	end

	a_start_idle: assert property (@(posedge Clck) disable iff (!rst_n)
		job_start |-> !pix_we);

	// also catches a job that changes before its last write
	a_rect_ordered: assert property (@(posedge Clck) disable iff (!rst_n)
		pix_we |-> (x_org <= job.x1) && (pix.y <= job.y1));

endmodule

/* rtl/scan_sequencer.sv */
`timescale 1ns/1ns

module scan_sequencer import paint_pkg::*;
#(
	parameter int BOARD_W = 8,
	parameter int BOARD_H = 8,
	parameter int CELL_PX = 8
)
(
	input  logic                        Clck,
	input  logic                        rst_n,
	input  cell_t [BOARD_W*BOARD_H-1:0] board,
	input  logic [COORD_BITS-1:0]       cursor_x,
	input  logic [COORD_BITS-1:0]       cursor_y,
	input  pal_t                        pal,
	input  logic                        job_done,
	output rect_t                       job,
	output logic                        job_start,
	output logic                        frame_done
);

	typedef enum logic [1:0] {S_SCAN, S_WAIT, S_CURSOR} state_t;

	state_t                state;
	logic [COORD_BITS-1:0] cell_x;
	logic [COORD_BITS-1:0] cell_y;
	logic                  on_cursor;
	cell_t                 cur_cell;
	logic                  last_cell;
	logic                  take_cell;
	logic [COORD_BITS-1:0] base_x;
	logic [COORD_BITS-1:0] base_y;
	logic [COORD_BITS-1:0] curs_x;
	logic [COORD_BITS-1:0] curs_y;
	logic [COORD_BITS-1:0] job_x0;
	logic [COORD_BITS-1:0] job_y0;
	logic [COORD_BITS-1:0] job_x1;
	logic [COORD_BITS-1:0] job_y1;
	pal_idx_t              job_idx;

	assign cur_cell  = board[cell_y * BOARD_W + cell_x];
	assign last_cell = (cell_x == COORD_BITS'(BOARD_W - 1)) &&
		(cell_y == COORD_BITS'(BOARD_H - 1));

	// the host may still update the board while frame_done is high,
	// so the first cell of a pass is looked at one cycle later
	assign take_cell = (state == S_SCAN) && !frame_done && (cur_cell != CELL_EMPTY);

	// top-left pixel of the scanned cell and of the cursor cell
	assign base_x = COORD_BITS'(cell_x * CELL_PX);
	assign base_y = COORD_BITS'(cell_y * CELL_PX);
	assign curs_x = COORD_BITS'(cursor_x * CELL_PX);
	assign curs_y = COORD_BITS'(cursor_y * CELL_PX);

	// color follows pal until the filler latches it on job_start
	assign job = '{x0: job_x0, y0: job_y0, x1: job_x1, y1: job_y1, color: pal[job_idx]};

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= S_SCAN;
			cell_x     <= '0;
			cell_y     <= '0;
			on_cursor  <= 1'b0;
			job_start  <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			job_start  <= 1'b0;
			frame_done <= 1'b0;
			case (state)
			S_SCAN:
				if (!frame_done)
				begin
					if (take_cell)
					begin
						job_start <= 1'b1;
						state     <= S_WAIT;
					end
					else if (last_cell)
						state <= S_CURSOR;
					// raster step with x fastest
					if (last_cell)
					begin
						cell_x <= '0;
						cell_y <= '0;
					end
					else if (cell_x == COORD_BITS'(BOARD_W - 1))
					begin
						cell_x <= '0;
						cell_y <= cell_y + 1'b1;
					end
					else
						cell_x <= cell_x + 1'b1;
				end
			S_WAIT:
				if (job_done)
				begin
					if (on_cursor)
					begin
						on_cursor  <= 1'b0;
						frame_done <= 1'b1;
						state      <= S_SCAN;
					end
					// counters are back at the origin once the last cell went out
					else if (cell_x == '0 && cell_y == '0)
						state <= S_CURSOR;
					else
						state <= S_SCAN;
				end
			S_CURSOR:
			begin
				job_start <= 1'b1;
				on_cursor <= 1'b1;
				state     <= S_WAIT;
			end
			default:
				state <= S_SCAN;
			endcase
		end
	end

	always_ff @(posedge Clck)
	begin
		if (state == S_CURSOR)
		begin
			// cursor covers the whole cell
			job_x0  <= curs_x;
			job_y0  <= curs_y;
			job_x1  <= curs_x + COORD_BITS'(CELL_PX - 1);
			job_y1  <= curs_y + COORD_BITS'(CELL_PX - 1);
			job_idx <= PAL_CURSOR;
		end
		else if (take_cell)
		begin
			// stone is inset by one pixel on every side
			job_x0  <= base_x + 1'b1;
			job_y0  <= base_y + 1'b1;
			job_x1  <= base_x + COORD_BITS'(CELL_PX - 2);
			job_y1  <= base_y + COORD_BITS'(CELL_PX - 2);
			job_idx <= pal_idx_t'(cur_cell - 1);
		end
	end

	a_frame_done_pulse: assert property (@(posedge Clck) disable iff (!rst_n)
		frame_done |=> !frame_done);

endmodule

/* rtl/palette_regs.sv */
`timescale 1ns/1ns

module palette_regs import paint_pkg::*;
(
	input  logic     Clck,
	input  logic     rst_n,
	input  logic     cfg_we,
	input  pal_idx_t cfg_idx,
	input  color_t   cfg_color,
	output pal_t     pal
);

	// host side register file for the drawing colors
	// the sequencer reads all four entries as a level

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// blue and green stones
			pal[PAL_P1]     <= 3'd1;
			pal[PAL_P2]     <= 3'd2;
			// yellow marks the winning line
			pal[PAL_WIN]    <= 3'd6;
			// red cursor
			pal[PAL_CURSOR] <= 3'd4;
		end
		else if (cfg_we)
		begin
			// one entry per strobe and visible on the next cycle
			pal[cfg_idx] <= cfg_color;
		end
	end

endmodule

/* rtl/paint_pkg.sv */
package paint_pkg;

	// screen coordinate width for a 1024 pixel axis
	localparam int COORD_BITS = 10;

	// one pixel color as {r, g, b}
	typedef logic [2:0] color_t;

	// state of one board cell
	typedef enum logic [1:0]
	{
		CELL_EMPTY = 2'd0,
		CELL_P1    = 2'd1,
		CELL_P2    = 2'd2,
		CELL_WIN   = 2'd3
	} cell_t;

	// palette slots where a stone uses its cell state minus one
	typedef enum logic [1:0]
	{
		PAL_P1     = 2'd0,
		PAL_P2     = 2'd1,
		PAL_WIN    = 2'd2,
		PAL_CURSOR = 2'd3
	} pal_idx_t;

	// filled rectangle with both corners inclusive
	typedef struct packed
	{
		logic [COORD_BITS-1:0] x0;
		logic [COORD_BITS-1:0] y0;
		logic [COORD_BITS-1:0] x1;
		logic [COORD_BITS-1:0] y1;
		color_t                color;
	} rect_t;

	// single write into the frame memory
	typedef struct packed
	{
		logic [COORD_BITS-1:0] x;
		logic [COORD_BITS-1:0] y;
		color_t                color;
	} pix_wr_t;

	// the four drawing colors indexed by pal_idx_t
	typedef color_t [3:0] pal_t;

endpackage
